// ==== ceres_param.sv ====
// Shared types for the memory and writeback stages; assumes XLEN of 32 with four byte lanes
package ceres_param;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Integer datapath width
  localparam int XLEN = 32;
  // Byte lanes in one memory word
  localparam int BYTE_LANES = XLEN / 8;

  //////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////

  // Load and store access size
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } rw_size_e;

  // Writeback source, bit 1 picks PC+4 and bit 0 picks load data
  typedef enum logic [1:0] {
    WB_ALU = 2'b00,
    WB_MEM = 2'b01,
    WB_PC4 = 2'b10
  } wb_sel_e;

  // Stall cause, level type, NO_STALL lets the pipe advance
  typedef enum logic [2:0] {
    NO_STALL     = 3'd0,
    IMISS_STALL  = 3'd1,
    DMISS_STALL  = 3'd2,
    ALU_STALL    = 3'd3,
    FENCEI_STALL = 3'd4
  } stall_e;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  // One memory word, seen whole, as byte lanes or as halfword lanes
  typedef union packed {
    logic [XLEN-1:0]                word;
    logic [BYTE_LANES-1:0][7:0]     lane_b;
    logic [BYTE_LANES/2-1:0][15:0]  lane_h;
  } mem_word_u;

  // One executed instruction on its way to memory and writeback
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd_addr;
    logic            rf_we;
    wb_sel_e         wb_sel;
    logic            mem_re;
    logic            mem_we;
    rw_size_e        rw_size;
    logic            ld_unsigned;
    // ALU result, also the address of a load or store
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] pc_incr;
  } ex_mem_t;

endpackage

// ==== data_ram.sv ====
// Single-port data RAM with registered read; storage is not reset and reads return old data on a same-word write
`timescale 1ns/10ps

module data_ram #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic                                clk_i,
  input  logic [$clog2(DMEM_DEPTH)-1:0]       addr_i,
  input  logic                                re_i,
  input  logic                                we_i,
  input  logic [ceres_param::BYTE_LANES-1:0]  be_i,
  input  ceres_param::mem_word_u              wdata_i,
  output ceres_param::mem_word_u              rdata_o
);
  import ceres_param::*;

  // Word array, one entry per word address
  mem_word_u mem_q [DMEM_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Each enabled byte lane is written on its own
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
        if (be_i[i]) begin
          mem_q[addr_i].lane_b[i] <= wdata_i.lane_b[i];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Registered read word
  // re_i arrives already gated by stall, so the word holds while stalled
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// ==== load_align.sv ====
// Combinational load aligner; assumes naturally aligned byte and half accesses in a 32-bit word
`timescale 1ns/10ps

module load_align (
  input  ceres_param::mem_word_u        word_i,
  input  logic [1:0]                    byte_off_i,
  input  ceres_param::rw_size_e         rw_size_i,
  input  logic                          unsigned_i,
  output logic [ceres_param::XLEN-1:0]  data_o
);
  import ceres_param::*;

  // Addressed byte and half, picked through the union lane views
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  // Sign bits, forced low for unsigned loads
  logic        byte_sign;
  logic        half_sign;

  // Byte lane by the full offset
  assign sel_byte = word_i.lane_b[byte_off_i];
  // Half lane by offset bit 1 only
  assign sel_half = word_i.lane_h[byte_off_i[1]];

  assign byte_sign = sel_byte[7] & ~unsigned_i;
  assign half_sign = sel_half[15] & ~unsigned_i;

  //////////////////////////////////////////////////////////////////////
  // Extension by size
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rw_size_i)
      BYTE: begin
        // LB and LBU
        data_o = {{(XLEN-8){byte_sign}}, sel_byte};
      end
      HALF: begin
        // LH and LHU
        data_o = {{(XLEN-16){half_sign}}, sel_half};
      end
      default: begin
        // LW passes the word as is
        data_o = word_i.word;
      end
    endcase
  end

endmodule

// ==== mem_stage.sv ====
// EX/MEM register with data memory request; needs upstream to hold ex_i during a stall, misaligned access unsupported
`timescale 1ns/10ps

module mem_stage #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  ceres_param::ex_mem_t                ex_i,
  input  ceres_param::stall_e                 stall_i,
  output logic [$clog2(DMEM_DEPTH)-1:0]       mem_addr_o,
  output logic                                mem_re_o,
  output logic                                mem_we_o,
  output logic [ceres_param::BYTE_LANES-1:0]  mem_be_o,
  output ceres_param::mem_word_u              mem_wdata_o,
  input  ceres_param::mem_word_u              mem_rdata_i,
  output ceres_param::ex_mem_t                mem_o,
  output logic [ceres_param::XLEN-1:0]        load_data_o
);
  import ceres_param::*;

  localparam int ADDR_W = $clog2(DMEM_DEPTH);

  // Instruction held for the memory cycle
  ex_mem_t    ex_q;
  // High when the pipe advances at the next edge
  logic       advance;
  // Byte offset of the incoming access
  logic [1:0] st_off;

  assign advance = (stall_i == NO_STALL);
  assign st_off  = ex_i.alu_result[1:0];

  //////////////////////////////////////////////////////////////////////
  // Memory request
  //////////////////////////////////////////////////////////////////////

  // Word index, upper address bits above the depth are dropped
  assign mem_addr_o = ex_i.alu_result[ADDR_W+1:2];

  // No new access while stalled
  assign mem_re_o = ex_i.valid & ex_i.mem_re & advance;
  assign mem_we_o = ex_i.valid & ex_i.mem_we & advance;

  // Byte enables and store data copied to every lane
  always_comb begin
    case (ex_i.rw_size)
      BYTE: begin
        mem_be_o         = 4'b0001 << st_off;
        mem_wdata_o.word = {BYTE_LANES{ex_i.store_data[7:0]}};
      end
      HALF: begin
        // Half lanes start at offset 0 or 2
        mem_be_o         = 4'b0011 << {st_off[1], 1'b0};
        mem_wdata_o.word = {(BYTE_LANES/2){ex_i.store_data[15:0]}};
      end
      default: begin
        mem_be_o         = '1;
        mem_wdata_o.word = ex_i.store_data;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  // Cleared to an invalid bubble, holds under any stall cause
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_q <= '0;
    end else if (advance) begin
      ex_q <= ex_i;
    end
  end

  assign mem_o = ex_q;

  // Load data from the registered RAM word
  load_align u_load_align (
    .word_i     (mem_rdata_i),
    .byte_off_i (ex_q.alu_result[1:0]),
    .rw_size_i  (ex_q.rw_size),
    .unsigned_i (ex_q.ld_unsigned),
    .data_o     (load_data_o)
  );

endmodule

// ==== writeback.sv ====
// Writeback select and register write gate; combinational, the 2'b11 select value is unused
`timescale 1ns/10ps

module writeback (
  input  ceres_param::stall_e           stall_i,
  input  logic                          flush_i,
  input  ceres_param::wb_sel_e          data_sel_i,
  input  logic [ceres_param::XLEN-1:0]  pc_incr_i,
  input  logic [ceres_param::XLEN-1:0]  alu_result_i,
  input  logic [ceres_param::XLEN-1:0]  read_data_i,
  input  logic                          rf_rw_en_i,
  output logic                          rf_rw_en_o,
  output logic [ceres_param::XLEN-1:0]  wb_data_o
);
  import ceres_param::*;

  // Any stall cause or a flush cancels the write this cycle
  assign rf_rw_en_o = rf_rw_en_i && !flush_i &&
                      !(stall_i inside {IMISS_STALL, DMISS_STALL, ALU_STALL, FENCEI_STALL});

  // Result mux
  always_comb begin
    case (data_sel_i)
      WB_MEM:  wb_data_o = read_data_i;
      // Link value for JAL and JALR
      WB_PC4:  wb_data_o = pc_incr_i;
      default: wb_data_o = alu_result_i;
    endcase
  end

endmodule

// ==== reg_file.sv ====
// 32 x XLEN register file, one write and two combinational reads; no write-to-read bypass
`timescale 1ns/10ps

module reg_file (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          we_i,
  input  logic [4:0]                    waddr_i,
  input  logic [ceres_param::XLEN-1:0]  wdata_i,
  input  logic [4:0]                    raddr_a_i,
  input  logic [4:0]                    raddr_b_i,
  output logic [ceres_param::XLEN-1:0]  rdata_a_o,
  output logic [ceres_param::XLEN-1:0]  rdata_b_o
);
  import ceres_param::*;

  // Architectural registers x0 to x31
  logic [XLEN-1:0] regs_q [32];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // x0 is never written so it stays at its reset value of zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Plain array reads, new value shows right after the write edge
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== lsu_wb_top.sv ====
// Memory and writeback back end; DMEM_DEPTH must be a power of two, inputs held by upstream under stall
`timescale 1ns/10ps

module lsu_wb_top #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  ceres_param::ex_mem_t          ex_i,
  input  ceres_param::stall_e           stall_i,
  input  logic                          flush_i,
  input  logic [4:0]                    rs1_addr_i,
  input  logic [4:0]                    rs2_addr_i,
  output logic [ceres_param::XLEN-1:0]  rs1_data_o,
  output logic [ceres_param::XLEN-1:0]  rs2_data_o
);
  import ceres_param::*;

  localparam int ADDR_W = $clog2(DMEM_DEPTH);

  // Memory request from the stage to the RAM
  logic [ADDR_W-1:0]     mem_addr;
  logic                  mem_re;
  logic                  mem_we;
  logic [BYTE_LANES-1:0] mem_be;
  mem_word_u             mem_wdata;
  mem_word_u             mem_rdata;
  // Instruction in its memory cycle and its aligned load value
  ex_mem_t               ex_mem;
  logic [XLEN-1:0]       load_data;
  // Register file write
  logic                  rf_we;
  logic [XLEN-1:0]       wb_data;

  //////////////////////////////////////////////////////////////////////
  // Memory stage and data RAM
  //////////////////////////////////////////////////////////////////////

  mem_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_mem_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ex_i        (ex_i),
    .stall_i     (stall_i),
    .mem_addr_o  (mem_addr),
    .mem_re_o    (mem_re),
    .mem_we_o    (mem_we),
    .mem_be_o    (mem_be),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .mem_o       (ex_mem),
    .load_data_o (load_data)
  );

  data_ram #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_data_ram (
    .clk_i   (clk_i),
    .addr_i  (mem_addr),
    .re_i    (mem_re),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Writeback and register file
  //////////////////////////////////////////////////////////////////////

  // A bubble never writes, so rf_we is qualified by valid
  writeback u_writeback (
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .data_sel_i   (ex_mem.wb_sel),
    .pc_incr_i    (ex_mem.pc_incr),
    .alu_result_i (ex_mem.alu_result),
    .read_data_i  (load_data),
    .rf_rw_en_i   (ex_mem.valid & ex_mem.rf_we),
    .rf_rw_en_o   (rf_we),
    .wb_data_o    (wb_data)
  );

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .we_i      (rf_we),
    .waddr_i   (ex_mem.rd_addr),
    .wdata_i   (wb_data),
    .raddr_a_i (rs1_addr_i),
    .raddr_b_i (rs2_addr_i),
    .rdata_a_o (rs1_data_o),
    .rdata_b_o (rs2_data_o)
  );

endmodule

// ==== tb_lsu_wb_assert.sv ====
// Writeback enable checks on the nets around the writeback instance sampled at the rising edge
`timescale 1ns/10ps

module tb_lsu_wb_assert (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input ceres_param::stall_e  stall_i,
  input logic                 flush_i,
  input ceres_param::wb_sel_e data_sel_i,
  input logic                 rf_rw_en_o
);
  import ceres_param::*;

  // Count of failed assertions
  int unsigned assert_fail_cnt = 0;

  // Flush or any stall cause blocks the register write
  property p_no_write_when_blocked;
    @(posedge clk_i) disable iff (!arst_n_i)
      (flush_i || stall_i != NO_STALL) |-> !rf_rw_en_o;
  endproperty

  // Select 2'b11 has no source
  property p_sel_valid_on_write;
    @(posedge clk_i) disable iff (!arst_n_i)
      rf_rw_en_o |-> (data_sel_i != 2'b11);
  endproperty

  a_no_write_when_blocked: assert property (p_no_write_when_blocked)
    else begin
      $error("register write enabled during flush or stall");
      assert_fail_cnt++;
    end
  a_sel_valid_on_write: assert property (p_sel_valid_on_write)
    else begin
      $error("writeback select uses the unused encoding");
      assert_fail_cnt++;
    end

endmodule

// Writeback ports as seen from the top level
bind lsu_wb_top tb_lsu_wb_assert u_wb_assert (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .stall_i    (stall_i),
  .flush_i    (flush_i),
  .data_sel_i (ex_mem.wb_sel),
  .rf_rw_en_o (rf_we)
);

// ==== tb_lsu_wb.sv ====
// Directed testbench for lsu_wb_top with DMEM_DEPTH of 256 that loads only words stored earlier
`timescale 1ns/10ps

module tb_lsu_wb;
  import ceres_param::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DMEM_DEPTH     = 256;
  localparam int ADDR_W         = $clog2(DMEM_DEPTH);
  // Byte address width of the data memory
  localparam int BA_W           = ADDR_W + 2;
  // About ten times the length of the directed tests
  localparam int TIMEOUT_CYCLES = 2000;

  logic            clk_i = 1'b0;
  logic            arst_n_i;
  ex_mem_t         ex_i;
  stall_e          stall_i;
  logic            flush_i;
  logic [4:0]      rs1_addr_i;
  logic [4:0]      rs2_addr_i;
  logic [XLEN-1:0] rs1_data_o;
  logic [XLEN-1:0] rs2_data_o;

  // Reference register file and byte memory
  logic [XLEN-1:0] ref_regs [32];
  logic [7:0]      ref_mem [DMEM_DEPTH*4];
  logic [31:0]     lfsr_q = 32'h290c7ed5;
  int              err_cnt;
  int              test_err_base;
  int              pass_cnt;
  int              fail_cnt;
  int              cycle_cnt;

  lsu_wb_top #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) dut (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ex_i       (ex_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .rs1_addr_i (rs1_addr_i),
    .rs2_addr_i (rs2_addr_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d clock cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and instruction builders
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Target register that is never x0
  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_bits(5);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  function automatic logic [BA_W-1:0] rand_word_addr();
    logic [31:0] r;
    r = rand_bits(ADDR_W);
    return {r[ADDR_W-1:0], 2'b00};
  endfunction

  function automatic ex_mem_t alu_ins(input logic [4:0] rd, input wb_sel_e sel,
                                      input logic [31:0] res, input logic [31:0] pc4);
    ex_mem_t ins;
    ins            = '0;
    ins.valid      = 1'b1;
    ins.rd_addr    = rd;
    ins.rf_we      = 1'b1;
    ins.wb_sel     = sel;
    ins.alu_result = res;
    ins.pc_incr    = pc4;
    return ins;
  endfunction

  // Load when st is low, store when high
  function automatic ex_mem_t mem_ins(input logic st, input logic [4:0] rd, input rw_size_e sz,
                                      input logic uns, input logic [BA_W-1:0] ba,
                                      input logic [31:0] d);
    ex_mem_t ins;
    ins             = '0;
    ins.valid       = 1'b1;
    ins.rd_addr     = rd;
    ins.rf_we       = ~st;
    ins.wb_sel      = WB_MEM;
    ins.mem_re      = ~st;
    ins.mem_we      = st;
    ins.rw_size     = sz;
    ins.ld_unsigned = uns;
    ins.alu_result  = 32'(ba);
    ins.store_data  = d;
    return ins;
  endfunction

  // Little endian read of the byte model with sign or zero extension
  function automatic logic [31:0] load_expect(input logic [BA_W-1:0] ba, input rw_size_e sz,
                                              input logic uns);
    case (sz)
      BYTE:    return {{24{ref_mem[ba][7] & ~uns}}, ref_mem[ba]};
      HALF:    return {{16{ref_mem[ba + BA_W'(1)][7] & ~uns}}, ref_mem[ba + BA_W'(1)],
                       ref_mem[ba]};
      default: return {ref_mem[ba + BA_W'(3)], ref_mem[ba + BA_W'(2)],
                       ref_mem[ba + BA_W'(1)], ref_mem[ba]};
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////////////////////////

  // Present one instruction, then a bubble until its write has landed
  task automatic issue(input ex_mem_t ins);
    ex_i = ins;
    @(negedge clk_i);
    ex_i = '0;
    @(negedge clk_i);
  endtask

  // Port A reads the register under test and port B its bitwise mirror
  // Both sampled mid low phase
  task automatic check_reg(input logic [4:0] addr, input string what);
    logic [4:0] addr_b;
    addr_b     = ~addr;
    rs1_addr_i = addr;
    rs2_addr_i = addr_b;
    #(CLK_PERIOD/4);
    if (rs1_data_o !== ref_regs[addr] || rs2_data_o !== ref_regs[addr_b]) begin
      $display("[FAIL] %0t ns: %s, x%0d reads %h and x%0d reads %h, expected %h and %h",
               $time, what, addr, rs1_data_o, addr_b, rs2_data_o, ref_regs[addr],
               ref_regs[addr_b]);
      err_cnt++;
    end
    @(negedge clk_i);
  endtask

  task automatic alu_write(input logic [4:0] rd, input wb_sel_e sel, input logic [31:0] res,
                           input logic [31:0] pc4);
    issue(alu_ins(rd, sel, res, pc4));
    if (rd != 5'd0)
      ref_regs[rd] = (sel == WB_PC4) ? pc4 : res;
  endtask

  task automatic store(input rw_size_e sz, input logic [BA_W-1:0] ba, input logic [31:0] d);
    issue(mem_ins(1'b1, 5'd0, sz, 1'b0, ba, d));
    ref_mem[ba] = d[7:0];
    if (sz != BYTE)
      ref_mem[ba + BA_W'(1)] = d[15:8];
    if (sz == WORD) begin
      ref_mem[ba + BA_W'(2)] = d[23:16];
      ref_mem[ba + BA_W'(3)] = d[31:24];
    end
  endtask

  task automatic load_check(input logic [4:0] rd, input rw_size_e sz, input logic uns,
                            input logic [BA_W-1:0] ba, input string what);
    issue(mem_ins(1'b0, rd, sz, uns, ba, 32'd0));
    ref_regs[rd] = load_expect(ba, sz, uns);
    check_reg(rd, what);
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      pass_cnt++;
      $display("Test %s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s failed with %0d bad values", name, err_cnt - test_err_base);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_and_x0();
    test_err_base = err_cnt;
    for (int i = 0; i < 32; i++) begin
      check_reg(5'(i), "reset value");
    end
    alu_write(5'd0, WB_ALU, rand_bits(32), 32'd0);
    check_reg(5'd0, "x0 after write");
    end_test("reset and x0");
  endtask

  task automatic alu_and_pc4();
    logic [4:0] rd;
    test_err_base = err_cnt;
    repeat (4) begin
      rd = rand_reg();
      alu_write(rd, WB_ALU, rand_bits(32), rand_bits(32));
      check_reg(rd, "ALU result");
      rd = rand_reg();
      alu_write(rd, WB_PC4, rand_bits(32), rand_bits(32));
      check_reg(rd, "PC+4 link");
    end
    end_test("ALU and PC+4");
  endtask

  task automatic store_merge();
    logic [BA_W-1:0] ba;
    logic [4:0]      rd;
    test_err_base = err_cnt;
    ba = rand_word_addr();
    rd = rand_reg();
    store(WORD, ba, rand_bits(32));
    load_check(rd, WORD, 1'b0, ba, "word store");
    store(HALF, ba + BA_W'(2), rand_bits(32));
    load_check(rd, WORD, 1'b0, ba, "half merge");
    store(BYTE, ba + BA_W'(1), rand_bits(32));
    load_check(rd, WORD, 1'b0, ba, "byte merge");
    end_test("store merge");
  endtask

  task automatic subword_loads();
    logic [BA_W-1:0] ba;
    logic [31:0]     d;
    logic [4:0]      rd;
    test_err_base = err_cnt;
    ba = rand_word_addr();
    d  = rand_bits(32);
    // Mixed sign bits across the byte and half lanes
    d[31] = 1'b1;
    d[15] = 1'b0;
    d[7]  = 1'b1;
    store(WORD, ba, d);
    for (int off = 0; off < 4; off++) begin
      rd = rand_reg();
      load_check(rd, BYTE, 1'b0, ba + BA_W'(off), "LB");
      load_check(rd, BYTE, 1'b1, ba + BA_W'(off), "LBU");
      if (off % 2 == 0) begin
        load_check(rd, HALF, 1'b0, ba + BA_W'(off), "LH");
        load_check(rd, HALF, 1'b1, ba + BA_W'(off), "LHU");
      end
    end
    end_test("sub-word loads");
  endtask

  task automatic stall_hold();
    logic [BA_W-1:0] ba;
    logic [BA_W-1:0] ba_held;
    logic [4:0]      rd;
    logic [31:0]     r;
    int              len;
    stall_e          cause;
    test_err_base = err_cnt;
    ba      = rand_word_addr();
    // Neighbour word read by the load that waits upstream
    ba_held = ba ^ BA_W'(4);
    rd      = rand_reg();
    store(WORD, ba, rand_bits(32));
    store(WORD, ba_held, rand_bits(32));
    alu_write(rd, WB_ALU, rand_bits(32), 32'd0);
    r     = rand_bits(5);
    // Stall of two to nine cycles
    len   = 2 + int'(r[2:0]);
    cause = stall_e'(3'(r[4:3]) + 3'd1);
    // Load reaches the memory stage, then the stall arrives
    ex_i = mem_ins(1'b0, rd, WORD, 1'b0, ba, 32'd0);
    @(negedge clk_i);
    // Next load held upstream must not replace the registered read word
    ex_i    = mem_ins(1'b0, 5'd0, WORD, 1'b0, ba_held, 32'd0);
    stall_i = cause;
    repeat (len) begin
      check_reg(rd, "stalled load");
    end
    stall_i = NO_STALL;
    @(negedge clk_i);
    ex_i         = '0;
    ref_regs[rd] = load_expect(ba, WORD, 1'b0);
    check_reg(rd, "load after stall");
    // Store held under stall, then dropped
    stall_i = cause;
    ex_i    = mem_ins(1'b1, 5'd0, WORD, 1'b0, ba, ~ref_regs[rd]);
    repeat (len) begin
      @(negedge clk_i);
    end
    ex_i = '0;
    @(negedge clk_i);
    stall_i = NO_STALL;
    @(negedge clk_i);
    load_check(rd, WORD, 1'b0, ba, "stalled store");
    end_test("stall");
  endtask

  task automatic flush_cancel();
    logic [4:0] rd;
    test_err_base = err_cnt;
    rd = rand_reg();
    alu_write(rd, WB_ALU, rand_bits(32), 32'd0);
    check_reg(rd, "value before flush");
    ex_i = alu_ins(rd, WB_ALU, ~ref_regs[rd], 32'd0);
    @(negedge clk_i);
    // Flush during the memory cycle
    ex_i    = '0;
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_reg(rd, "flushed write");
    end_test("flush");
  endtask

  initial begin
    arst_n_i   = 1'b0;
    ex_i       = '0;
    stall_i    = NO_STALL;
    flush_i    = 1'b0;
    rs1_addr_i = 5'd0;
    rs2_addr_i = 5'd0;
    ref_regs   = '{default: '0};
    repeat (16) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    reset_and_x0();
    alu_and_pc4();
    store_merge();
    subword_loads();
    stall_hold();
    flush_cancel();
    $display("Summary: %0d tests passed, %0d tests failed, %0d bad values, %0d assert errors",
             pass_cnt, fail_cnt, err_cnt, dut.u_wb_assert.assert_fail_cnt);
    if (fail_cnt == 0 && dut.u_wb_assert.assert_fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
ceres_param.sv
data_ram.sv
load_align.sv
mem_stage.sv
writeback.sv
reg_file.sv
lsu_wb_top.sv
tb_lsu_wb_assert.sv
tb_lsu_wb.sv

// ==== Makefile ====
# Verilator build and run of the memory and writeback testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_wb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
